/* sources.f */
+incdir+hw
hw/normUnitPkg.sv
hw/normBus.sv
hw/LeadCountS32.sv
hw/barrelShift32.sv
hw/normIssue.sv
hw/normExecute.sv
hw/normUnit.sv
testbench/normUnit_asserts.sv
testbench/normUnit_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = normUnit_tb
FILELIST = sources.f
OBJDIR   = obj_dir
LOG      = sim.log
PASSMSG  = Result: PASSED

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* testbench/normUnit_tb.sv */
`include "normUnit_defs.svh"

module normUnit_tb;
	// ----------------------------------------------------------
	// Run length
	// ----------------------------------------------------------
	localparam int RESET_CYCLES   = 3;
	localparam int CORNER_REQS    = 25;  // Five corner values times five ops
	localparam int SWEEP_REQS     = 64;  // SHL and SRA over amounts 0..31
	localparam int RANDOM_SLOTS   = 600; // Random phase, one cycle each
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + CORNER_REQS + SWEEP_REQS
		+ RANDOM_SLOTS + 50;

	// Expected entry for one request in flight
	typedef struct {
		normUnitPkg::normOp_t  op;
		logic [`NU_DATA_W-1:0] operand;
		logic [`NU_DATA_W-1:0] result;
		int                    due;     // Cycle at which outValid is seen
	} expectRec_t;

	logic                   clk;
	logic                   rst;
	logic                   inValid;
	normUnitPkg::normOp_t   inOp;
	logic [`NU_DATA_W-1:0]  inOperand;
	logic [`NU_SHAMT_W-1:0] inAmount;
	logic                   outValid;
	logic [`NU_DATA_W-1:0]  outResult;

	expectRec_t             pending[$];     // Model queue, request order
	expectRec_t             headRec;        // Entry being retired
	logic                   strobeDue;      // Model says outValid now
	logic [31:0]            lfsrState;      // Random source
	int                     cycleCount = 0; // Edges since time zero

	normUnit u_dut(
		.clk       (clk),
		.rst       (rst),
		.inValid   (inValid),
		.inOp      (inOp),
		.inOperand (inOperand),
		.inAmount  (inAmount),
		.outValid  (outValid),
		.outResult (outResult)
	);

	always #5 clk = ~clk;

	// ----------------------------------------------------------
	// Random source and reference model
	// ----------------------------------------------------------
	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] randBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			bits      = {bits[30:0], lfsrState[0]};
			lfsrState = {1'b0, lfsrState[31:1]} ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
		end
		return bits;
	endfunction

	// Uniform over the five opcodes
	function automatic normUnitPkg::normOp_t randOp();
		logic [2:0] code;
		code = 3'd7;
		while (code > 3'd4)
			code = randBits(3);
		return normUnitPkg::normOp_t'(code);
	endfunction

	// Sign spread word, so every leading count shows up
	function automatic logic [`NU_DATA_W-1:0] randOperand();
		logic [`NU_DATA_W-1:0] word;
		logic [4:0]            spread;
		word   = randBits(32);
		spread = randBits(5);
		return $signed(word) >>> spread;
	endfunction

	// Leading bits equal to bit 31, walked one bit at a time
	function automatic logic [5:0] leadSignCount(input logic [`NU_DATA_W-1:0] v);
		logic [5:0] cnt;
		logic       run;
		cnt = 6'd1; // Sign bit counts itself
		run = 1'b1;
		for (int i = `NU_DATA_W - 2; i >= 0; i--)
		begin
			if (run && v[i] == v[`NU_DATA_W-1])
				cnt = cnt + 6'd1;
			else
				run = 1'b0;
		end
		return cnt;
	endfunction

	function automatic logic [`NU_DATA_W-1:0] modelResult(
		input normUnitPkg::normOp_t  op,
		input logic [`NU_DATA_W-1:0] operand,
		input logic [4:0]            amount
	);
		logic [5:0]            lead;
		logic [`NU_DATA_W-1:0] res;
		lead = leadSignCount(operand);
		case (op)
			normUnitPkg::OP_CLS:  res = {26'd0, lead};
			normUnitPkg::OP_CLZ:  res = operand[31] ? 32'd0 : {26'd0, lead};
			normUnitPkg::OP_NORM: res = operand << (lead - 6'd1); // L of 32 shifts 31
			normUnitPkg::OP_SHL:  res = operand << amount;
			normUnitPkg::OP_SRA:  res = $signed(operand) >>> amount; // Sign fill
			default:              res = 'x;
		endcase
		return res;
	endfunction

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	task automatic checkValue(
		input logic [`NU_DATA_W-1:0] got,
		input logic [`NU_DATA_W-1:0] expected,
		input string                 what
	);
		if (got !== expected)
		begin
			$display("ERROR at time %0t: %s mismatch, got %h expected %h",
				$time, what, got, expected);
			$display("Result: FAILED");
			$fatal(1, "Mismatch found");
		end
	endtask

	// Compare strobe timing and retire results in request order
	always @(posedge clk)
	begin
		if (!rst)
		begin
			strobeDue = (pending.size() != 0) && (pending[0].due == cycleCount);
			checkValue({31'd0, outValid}, {31'd0, strobeDue}, "outValid");
			if (outValid)
			begin
				headRec = pending.pop_front();
				checkValue(outResult, headRec.result,
					$sformatf("%s result for %h", headRec.op.name(), headRec.operand));
			end
		end
	end

	// Cycle counter and hang guard
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Result: FAILED");
			$fatal(1, "Simulation timed out");
		end
	end

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------
	task automatic issueRequest(
		input normUnitPkg::normOp_t  op,
		input logic [`NU_DATA_W-1:0] operand,
		input logic [4:0]            amount
	);
		expectRec_t rec;
		@(posedge clk);
		inValid   <= 1'b1;
		inOp      <= op;
		inOperand <= operand;
		inAmount  <= amount;
		rec.op      = op;
		rec.operand = operand;
		rec.result  = modelResult(op, operand, amount);
		rec.due     = cycleCount + 3; // Sampled next edge, seen two edges later
		pending.push_back(rec);
	endtask

	// Gap cycle, payload is junk
	task automatic driveIdle(
		input normUnitPkg::normOp_t  op,
		input logic [`NU_DATA_W-1:0] operand,
		input logic [4:0]            amount
	);
		@(posedge clk);
		inValid   <= 1'b0;
		inOp      <= op;
		inOperand <= operand;
		inAmount  <= amount;
	endtask

	initial
	begin
		logic [`NU_DATA_W-1:0] corners [0:4];
		normUnitPkg::normOp_t  op;
		logic [`NU_DATA_W-1:0] operand;
		logic [4:0]            amount;

		lfsrState  = 32'h616a69be;
		clk        = 1'b0;
		rst        = 1'b1;
		inValid    = 1'b0;
		inOp       = normUnitPkg::OP_CLS;
		inOperand  = '0;
		inAmount   = '0;
		corners[0] = 32'h0000_0000;
		corners[1] = 32'hFFFF_FFFF;
		corners[2] = 32'h8000_0000;
		corners[3] = 32'h7FFF_FFFF;
		corners[4] = 32'h0000_0001;

		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;

		// Corner operands through every op, back to back
		for (int c = 0; c < 5; c++)
		begin
			for (int o = 0; o < 5; o++)
				issueRequest(normUnitPkg::normOp_t'(o), corners[c], randBits(5));
		end

		// Every shift amount in both directions
		for (int a = 0; a < 32; a++)
		begin
			issueRequest(normUnitPkg::OP_SHL, randBits(32), a[4:0]);
			issueRequest(normUnitPkg::OP_SRA, randBits(32), a[4:0]);
		end

		// Random mix with gaps, about three in four cycles busy
		for (int n = 0; n < RANDOM_SLOTS; n++)
		begin
			op      = randOp();
			operand = randOperand();
			amount  = randBits(5);
			if (|randBits(2))
				issueRequest(op, operand, amount);
			else
				driveIdle(op, operand, amount);
		end

		driveIdle(normUnitPkg::OP_CLS, '0, '0);
		repeat (5) @(posedge clk); // Drain the two edge pipeline, catch a stray strobe

		if (pending.size() == 0)
		begin
			$display("Result: PASSED");
			$finish;
		end
		else
		begin
			$display("Requests left without a result at the end of the run");
			$display("Result: FAILED");
			$fatal(1, "Expected queue not empty");
		end
	end
endmodule

/* testbench/normUnit_asserts.sv */
module normUnit_asserts(
	input logic clk,
	input logic rst,
	input logic inValid,
	input logic outValid
);
	logic clockSeen = 1'b0; // Set once the first edge has cleared outValid

	always @(posedge clk)
		clockSeen <= 1'b1;

	// ----------------------------------------------------------
	// Reset behavior
	// ----------------------------------------------------------
	resetQuiet: assert property (@(posedge clk) (rst && clockSeen) |-> !outValid)
		else $error("outValid high while reset is asserted");

	// ----------------------------------------------------------
	// Fixed two edge latency
	// ----------------------------------------------------------
	// Every accepted request gives a strobe
	requestAnswered: assert property (@(posedge clk) disable iff (rst)
		inValid |-> ##2 outValid)
		else $error("Request without outValid two cycles later");

	// No strobe without a request behind it
	noStrayStrobe: assert property (@(posedge clk) disable iff (rst)
		outValid |-> $past(inValid, 2))
		else $error("outValid without a request two cycles earlier");
endmodule

// Attach to every normUnit instance
bind normUnit normUnit_asserts uAsserts(
	.clk      (clk),
	.rst      (rst),
	.inValid  (inValid),
	.outValid (outValid)
);

/* hw/normUnit.sv */
`include "normUnit_defs.svh"

module normUnit(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   inValid,   // Request strobe
	input  normUnitPkg::normOp_t   inOp,
	input  logic [`NU_DATA_W-1:0]  inOperand,
	input  logic [`NU_SHAMT_W-1:0] inAmount,  // Used by SHL and SRA
	output logic                   outValid,  // Two edges after inValid
	output logic [`NU_DATA_W-1:0]  outResult
);
	// ----------------------------------------------------------
	// Stage link
	// ----------------------------------------------------------
	normBus issueBus();

	// Stage 1, count and shift setup
	normIssue uIssue(
		.clk       (clk),
		.rst       (rst),
		.inValid   (inValid),
		.inOp      (inOp),
		.inOperand (inOperand),
		.inAmount  (inAmount),
		.bus       (issueBus.issue)
	);

	// Stage 2, shift, select and register
	normExecute uExecute(
		.clk       (clk),
		.rst       (rst),
		.bus       (issueBus.execute),
		.outValid  (outValid),
		.outResult (outResult)
	);
endmodule

/* hw/normExecute.sv */
`include "normUnit_defs.svh"

module normExecute(
	input  logic                  clk,
	input  logic                  rst,
	normBus.execute               bus,
	output logic                  outValid,
	output logic [`NU_DATA_W-1:0] outResult
);
	logic [`NU_DATA_W-1:0] shiftedValue; // Shifter output
	logic [`NU_DATA_W-1:0] resultNext;   // Selected result
	logic                  isCount;      // CLS or CLZ in flight

	// ----------------------------------------------------------
	// Shift and select
	// ----------------------------------------------------------
	barrelShift32 uShift(
		.data    (bus.operand),
		.amount  (bus.shiftAmount),
		.mode    (bus.shiftMode),
		.shifted (shiftedValue)
	);

	assign isCount = (bus.op == normUnitPkg::OP_CLS) ||
		(bus.op == normUnitPkg::OP_CLZ);

	// NORM, SHL and SRA all take the shifter
	assign resultNext = isCount ? bus.countResult : shiftedValue;

	// ----------------------------------------------------------
	// Output register
	// ----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
			outValid <= 1'b0;
		else
			outValid <= bus.valid;
	end

	// Result holds its last value between strobes
	always_ff @(posedge clk)
	begin
		if (bus.valid)
			outResult <= resultNext;
	end
endmodule

/* hw/normIssue.sv */
`include "normUnit_defs.svh"

module normIssue(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   inValid,
	input  normUnitPkg::normOp_t   inOp,
	input  logic [`NU_DATA_W-1:0]  inOperand,
	input  logic [`NU_SHAMT_W-1:0] inAmount,
	normBus.issue                  bus
);
	logic [`NU_COUNT_W-1:0]  leadCount;  // L of the incoming operand
	logic [`NU_DATA_W-1:0]   countValue; // CLS or CLZ result
	logic [`NU_SHAMT_W-1:0]  amountNext; // Shift amount for execute
	normUnitPkg::shiftMode_t modeNext;   // Shift direction for execute

	LeadCountS32 uLeadCount(
		.value  (inOperand),
		.result (leadCount)
	);

	// ----------------------------------------------------------
	// Count result
	// ----------------------------------------------------------
	always_comb
	begin
		countValue = {{(`NU_DATA_W-`NU_COUNT_W){1'b0}}, leadCount};
		// Negative operand has no leading zeros
		if (inOp == normUnitPkg::OP_CLZ && inOperand[`NU_DATA_W-1])
			countValue = '0;
	end

	// ----------------------------------------------------------
	// Shift amount and mode
	// ----------------------------------------------------------
	always_comb
	begin
		amountNext = inAmount; // SHL and SRA use the input amount
		modeNext   = normUnitPkg::SHIFT_LEFT;
		case (inOp)
			// L of 32 wraps to 0 in five bits, so minus one gives 31
			normUnitPkg::OP_NORM: amountNext = leadCount[`NU_SHAMT_W-1:0] - 1'b1;
			normUnitPkg::OP_SRA:  modeNext   = normUnitPkg::SHIFT_RIGHT_ARITH;
			default:              modeNext   = normUnitPkg::SHIFT_LEFT;
		endcase
	end

	// ----------------------------------------------------------
	// Stage register
	// ----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
			bus.valid <= 1'b0;
		else
			bus.valid <= inValid;
	end

	// Payload only loads on a request
	always_ff @(posedge clk)
	begin
		if (inValid)
		begin
			bus.op          <= inOp;
			bus.operand     <= inOperand;
			bus.countResult <= countValue;
			bus.shiftAmount <= amountNext;
			bus.shiftMode   <= modeNext;
		end
	end
endmodule

/* hw/barrelShift32.sv */
`include "normUnit_defs.svh"

module barrelShift32(
	input  logic [`NU_DATA_W-1:0]  data,
	input  logic [`NU_SHAMT_W-1:0] amount,
	input  normUnitPkg::shiftMode_t mode,
	output logic [`NU_DATA_W-1:0]  shifted
);
	// ----------------------------------------------------------
	// Logarithmic stages of 1, 2, 4, 8 and 16
	// ----------------------------------------------------------
	logic [`NU_DATA_W-1:0] stage [0:`NU_SHAMT_W]; // Stage 0 is the input
	logic                  signBit;               // Fill for right shifts

	assign signBit  = data[`NU_DATA_W-1]; // Stays on top through all right stages
	assign stage[0] = data;

	for (genvar s = 0; s < `NU_SHAMT_W; s++)
	begin : gStage
		localparam int stepSize = 1 << s;

		logic [`NU_DATA_W-1:0] leftVal;  // Zero filled
		logic [`NU_DATA_W-1:0] rightVal; // Sign filled

		assign leftVal  = {stage[s][`NU_DATA_W-1-stepSize:0], {stepSize{1'b0}}};
		assign rightVal = {{stepSize{signBit}}, stage[s][`NU_DATA_W-1:stepSize]};

		// Amount bit s enables this stage
		always_comb
		begin
			if (!amount[s])
				stage[s+1] = stage[s];
			else if (mode == normUnitPkg::SHIFT_LEFT)
				stage[s+1] = leftVal;
			else
				stage[s+1] = rightVal;
		end
	end

	assign shifted = stage[`NU_SHAMT_W];
endmodule

/* hw/LeadCountS32.sv */
`include "normUnit_defs.svh"

module LeadCountS32(
	input  logic [`NU_DATA_W-1:0]  value,
	output logic [`NU_COUNT_W-1:0] result
);
	// ----------------------------------------------------------
	// Byte level encoders
	// ----------------------------------------------------------

	// Leading zeros of one byte, only meaningful when byte is not zero
	function automatic logic [2:0] leadZero8(input logic [7:0] b);
		logic [2:0] cnt;
		casez (b)
			8'b1???????: cnt = 3'd0;
			8'b01??????: cnt = 3'd1;
			8'b001?????: cnt = 3'd2;
			8'b0001????: cnt = 3'd3;
			8'b00001???: cnt = 3'd4;
			8'b000001??: cnt = 3'd5;
			8'b0000001?: cnt = 3'd6;
			8'b00000001: cnt = 3'd7;
			default:     cnt = 3'd0; // All zero, masked by hit flag
		endcase
		return cnt;
	endfunction

	// Pick the topmost byte with a hit and prefix its byte offset
	function automatic logic [`NU_COUNT_W-1:0] mergeBytes(
		input logic [3:0]  hit,
		input logic [11:0] cnt
	);
		logic [`NU_COUNT_W-1:0] total;
		total = 6'd32; // No hit anywhere, whole word equal
		// Later iterations override, so the top byte wins
		for (int i = 0; i < 4; i++)
		begin
			if (hit[i])
				total = {1'b0, 2'(3 - i), cnt[3*i +: 3]};
		end
		return total;
	endfunction

	// ----------------------------------------------------------
	// Per byte results for both polarities
	// ----------------------------------------------------------
	logic [3:0]  zeroHit;  // Byte holds a one
	logic [3:0]  oneHit;   // Byte holds a zero
	logic [11:0] zeroCnt;  // Leading zeros per byte, 3 bits each
	logic [11:0] oneCnt;   // Leading ones per byte, 3 bits each

	for (genvar i = 0; i < 4; i++)
	begin : gByte
		assign zeroHit[i]        = |value[8*i +: 8];
		assign oneHit[i]         = ~&value[8*i +: 8];
		assign zeroCnt[3*i +: 3] = leadZero8(value[8*i +: 8]);
		// Leading ones are leading zeros of the inverted byte
		assign oneCnt[3*i +: 3]  = leadZero8(~value[8*i +: 8]);
	end

	// ----------------------------------------------------------
	// Word level merge
	// ----------------------------------------------------------
	logic [`NU_COUNT_W-1:0] zeroLead; // Leading zeros of the word
	logic [`NU_COUNT_W-1:0] oneLead;  // Leading ones of the word

	assign zeroLead = mergeBytes(zeroHit, zeroCnt);
	assign oneLead  = mergeBytes(oneHit, oneCnt);

	// Sign bit picks the polarity, giving L in 1..32
	assign result = value[`NU_DATA_W-1] ? oneLead : zeroLead;
endmodule

/* hw/normBus.sv */
`include "normUnit_defs.svh"

// One issued operation, issue stage to execute stage
interface normBus;
	logic                       valid;       // One cycle strobe per operation
	normUnitPkg::normOp_t       op;          // Opcode carried along
	logic [`NU_DATA_W-1:0]      operand;     // Raw operand for the shifter
	logic [`NU_DATA_W-1:0]      countResult; // CLS or CLZ value, zero extended
	logic [`NU_SHAMT_W-1:0]     shiftAmount; // Count minus one or input amount
	normUnitPkg::shiftMode_t    shiftMode;   // Left or arithmetic right

	// Fields hold meaning only while valid is high
	modport issue(
		output valid,
		output op,
		output operand,
		output countResult,
		output shiftAmount,
		output shiftMode
	);

	modport execute(
		input valid,
		input op,
		input operand,
		input countResult,
		input shiftAmount,
		input shiftMode
	);
endinterface

/* hw/normUnitPkg.sv */
package normUnitPkg;

	// ----------------------------------------------------------
	// Operation codes
	// ----------------------------------------------------------
	typedef enum logic [2:0] {
		OP_CLS  = 3'd0, // Count leading sign bits
		OP_CLZ  = 3'd1, // Count leading zeros, 0 for negative
		OP_NORM = 3'd2, // Shift left by count minus one
		OP_SHL  = 3'd3, // Logical left by amount
		OP_SRA  = 3'd4  // Arithmetic right by amount
	} normOp_t;

	// Shifter direction
	typedef enum logic {
		SHIFT_LEFT        = 1'b0, // Zero fill from the right
		SHIFT_RIGHT_ARITH = 1'b1  // Sign fill from the left
	} shiftMode_t;

endpackage

/* hw/normUnit_defs.svh */
`ifndef NORM_UNIT_DEFS_SVH
`define NORM_UNIT_DEFS_SVH

// ----------------------------------------------------------
// Datapath widths of the normalize unit
// ----------------------------------------------------------
`define NU_DATA_W  32 // Operand and result width
`define NU_SHAMT_W 5  // Shift amount, covers 0..31
`define NU_COUNT_W 6  // Leading count, covers 1..32

`endif
